/* source/keccak_geom_pkg.sv */
// Keccak-f[200] state geometry constants and datapath typedefs
`default_nettype none

package keccak_geom_pkg;

  ////////////////////////////////
  // Geometry
  ////////////////////////////////

  // Lane width in bits, Keccak-f[200] uses 8
  parameter int LaneW = 8;
  // 5 x 5 lanes
  parameter int NumLanes = 25;
  parameter int StateW = LaneW * NumLanes;

  // Keccak-f rounds, 12 + 2*log2(LaneW)
  parameter int NumRounds = 18;
  // Enough bits for round + RoundsPerClock - 1
  parameter int RoundW = 5;

  ////////////////////////////////
  // Datapath types
  ////////////////////////////////

  typedef logic [LaneW-1:0] lane_t;

  // Lane x + 5*y sits at bits LaneW*(x+5y) upward
  typedef logic [StateW-1:0] state_t;

  typedef logic [RoundW-1:0] round_t;

endpackage

`default_nettype wire

/* source/keccak_ctrl_pkg.sv */
// Round FSM state encoding and engine status struct
`default_nettype none

package keccak_ctrl_pkg;

  // Round controller states
  typedef enum logic [1:0] {
    StIdle          = 2'b00,
    StActive        = 2'b01,
    // Sink state, never entered in normal operation
    StError         = 2'b10,
    StTerminalError = 2'b11
  } round_st_e;

  // Status reported by the engine
  typedef struct packed {
    logic ready;        // Idle, run_i accepted
    logic complete;     // One-cycle pulse at end of permutation
    logic fsm_error;    // FSM in terminal error
    logic count_error;  // Round counter copies disagree
    logic clear_error;  // Storage cleared outside idle
  } round_status_t;

endpackage

`default_nettype wire

/* source/keccak_rc_table.sv */
// Iota round constant lookup, truncated to lane width
`default_nettype none

module keccak_rc_table (
  input  keccak_geom_pkg::round_t round_i,
  output keccak_geom_pkg::lane_t  rc_o
);

  // Low 8 bits of the standard Keccak round constants
  // Derived from the x^8+x^6+x^5+x^4+1 LFSR; only bit positions 0, 1, 3, 7 land in a lane
  always_comb begin
    case (round_i)
      5'd0:    rc_o = 8'h01;
      5'd1:    rc_o = 8'h82;
      5'd2:    rc_o = 8'h8a;
      5'd3:    rc_o = 8'h00;
      5'd4:    rc_o = 8'h8b;
      5'd5:    rc_o = 8'h01;
      5'd6:    rc_o = 8'h81;
      5'd7:    rc_o = 8'h09;
      5'd8:    rc_o = 8'h8a;
      5'd9:    rc_o = 8'h88;
      5'd10:   rc_o = 8'h09;
      5'd11:   rc_o = 8'h0a;
      5'd12:   rc_o = 8'h8b;
      5'd13:   rc_o = 8'h8b;
      5'd14:   rc_o = 8'h89;
      5'd15:   rc_o = 8'h03;
      5'd16:   rc_o = 8'h02;
      5'd17:   rc_o = 8'h80;
      // Past the last round
      default: rc_o = 8'h00;
    endcase
  end

endmodule

`default_nettype wire

/* source/keccak_step.sv */
// Combinational Keccak round: theta, rho, pi, chi and iota
`default_nettype none

module keccak_step (
  input  keccak_geom_pkg::round_t round_i,
  input  keccak_geom_pkg::state_t state_i,
  output keccak_geom_pkg::state_t state_o
);
  import keccak_geom_pkg::*;

  // Rho offsets modulo LaneW, lane index x + 5*y
  localparam int RhoOffset [NumLanes] = '{
    0, 1, 6, 4, 3,
    4, 4, 6, 7, 4,
    3, 2, 3, 1, 7,
    1, 5, 7, 5, 0,
    2, 2, 5, 0, 6
  };

  // Rotate towards the MSB
  function automatic lane_t rotl(lane_t a, int n);
    return lane_t'((a << n) | (a >> (LaneW - n)));
  endfunction

  lane_t a [NumLanes];  // Input lanes
  lane_t c [5];         // Column parities
  lane_t d [5];         // Theta column term
  lane_t b [NumLanes];  // After theta, rho and pi
  lane_t e [NumLanes];  // After chi
  lane_t rc;

  keccak_rc_table u_rc_table (
    .round_i (round_i),
    .rc_o    (rc)
  );

  always_comb begin
    // Unpack lanes
    for (int i = 0; i < NumLanes; i++) begin
      a[i] = state_i[LaneW*i +: LaneW];
    end

    // Theta
    for (int x = 0; x < 5; x++) begin
      c[x] = a[x] ^ a[x+5] ^ a[x+10] ^ a[x+15] ^ a[x+20];
    end
    for (int x = 0; x < 5; x++) begin
      d[x] = c[(x+4)%5] ^ rotl(c[(x+1)%5], 1);
    end

    // Rho then pi, lane (x,y) moves to (y, 2x+3y)
    for (int y = 0; y < 5; y++) begin
      for (int x = 0; x < 5; x++) begin
        b[y + 5*((2*x + 3*y) % 5)] = rotl(a[x+5*y] ^ d[x], RhoOffset[x+5*y]);
      end
    end

    // Chi, nonlinear mix along each row
    for (int y = 0; y < 5; y++) begin
      for (int x = 0; x < 5; x++) begin
        e[x+5*y] = b[x+5*y] ^ (~b[(x+1)%5 + 5*y] & b[(x+2)%5 + 5*y]);
      end
    end

    // Repack, iota on lane 0
    for (int i = 0; i < NumLanes; i++) begin
      state_o[LaneW*i +: LaneW] = (i == 0) ? (e[i] ^ rc) : e[i];
    end
  end

endmodule

`default_nettype wire

/* source/keccak_round_count.sv */
// Redundant round counter with inverted shadow copy and mismatch flag
`default_nettype none

module keccak_round_count #(
  parameter int RoundsPerClock = 1
) (
  input  logic                    clk_i,
  input  logic                    rst_b,
  input  logic                    clr_i,
  input  logic                    incr_i,
  output keccak_geom_pkg::round_t cnt_o,
  output logic                    err_o
);
  import keccak_geom_pkg::*;

  localparam round_t Step = round_t'(RoundsPerClock);

  round_t cnt_q;
  // Shadow copy held inverted, so it counts down
  round_t cnt_inv_q;

  always_ff @(posedge clk_i or negedge rst_b) begin
    if (!rst_b) begin
      cnt_q     <= '0;
      cnt_inv_q <= '1;
    end else if (clr_i) begin
      cnt_q     <= '0;
      cnt_inv_q <= '1;
    end else if (incr_i) begin
      cnt_q     <= cnt_q + Step;
      cnt_inv_q <= cnt_inv_q - Step;
    end
  end

  assign cnt_o = cnt_q;
  // Any upset in either copy shows up here
  assign err_o = (cnt_q != ~cnt_inv_q);

  // Controller clears before the count runs past the last round
  CntInRange_A: assert property (@(posedge clk_i) disable iff (!rst_b)
    cnt_q <= round_t'(NumRounds));

endmodule

`default_nettype wire

/* source/keccak_round.sv */
// Round control FSM, state storage with message XOR, step chain and status
`default_nettype none

module keccak_round #(
  parameter int RoundsPerClock = 1
) (
  input  logic                           clk_i,
  input  logic                           rst_b,
  input  logic                           zeroize_i,
  input  logic                           run_i,
  input  logic                           squeezing_i,
  input  logic                           clear_i,
  input  keccak_geom_pkg::state_t        data_i,
  output keccak_geom_pkg::state_t        state_o,
  output keccak_ctrl_pkg::round_status_t status_o
);
  import keccak_geom_pkg::*;
  import keccak_ctrl_pkg::*;

  // Storage control
  logic update_storage;
  logic rst_storage;
  logic xor_message;
  // Round counter control
  logic inc_rnd;
  logic rst_rnd;
  logic rnd_eq_end;
  // Completion and errors
  logic complete_d;
  logic complete_q;
  logic fsm_error;
  logic count_error;
  logic clear_error;

  round_st_e st_q, st_d;
  round_t    round;
  state_t    storage;
  state_t    storage_d;
  state_t    chain [RoundsPerClock+1];

  ////////////////////////////////
  // Round FSM
  ////////////////////////////////

  // Last group of rounds starts here
  assign rnd_eq_end = (round == round_t'(NumRounds - RoundsPerClock));

  always_comb begin
    st_d           = st_q;
    update_storage = 1'b0;
    rst_storage    = 1'b0;
    xor_message    = 1'b0;
    inc_rnd        = 1'b0;
    rst_rnd        = 1'b0;
    complete_d     = 1'b0;
    fsm_error      = 1'b0;

    case (st_q)
      StIdle: begin
        // Clear wins over run
        if (clear_i) begin
          rst_storage = 1'b1;
        end else if (run_i) begin
          st_d           = StActive;
          // Squeeze keeps storage as is
          xor_message    = ~squeezing_i;
          update_storage = ~squeezing_i;
        end
      end
      StActive: begin
        update_storage = 1'b1;
        if (rnd_eq_end) begin
          st_d       = StIdle;
          rst_rnd    = 1'b1;
          complete_d = 1'b1;
        end else begin
          inc_rnd = 1'b1;
        end
      end
      StError: begin
        st_d = StError;
      end
      StTerminalError: begin
        fsm_error = 1'b1;
      end
      default: begin
        st_d      = StTerminalError;
        fsm_error = 1'b1;
      end
    endcase

    // Zeroize overrides any state
    if (zeroize_i) begin
      st_d = StIdle;
    end
  end

  always_ff @(posedge clk_i or negedge rst_b) begin
    if (!rst_b) begin
      st_q <= StIdle;
    end else begin
      st_q <= st_d;
    end
  end

  ////////////////////////////////
  // State storage
  ////////////////////////////////

  // Absorb XORs data in, otherwise take the last step output
  assign storage_d = xor_message ? (storage ^ data_i) : chain[RoundsPerClock];

  always_ff @(posedge clk_i or negedge rst_b) begin
    if (!rst_b) begin
      storage <= '0;
    end else if (zeroize_i || rst_storage) begin
      storage <= '0;
    end else if (update_storage) begin
      storage <= storage_d;
    end
  end

  assign state_o = storage;

  // Storage clear only legal in idle with clear_i up
  assign clear_error = rst_storage && ((st_q != StIdle) || !clear_i);

  ////////////////////////////////
  // Step chain and counter
  ////////////////////////////////

  assign chain[0] = storage;

  for (genvar k = 0; k < RoundsPerClock; k++) begin : gen_step
    keccak_step u_step (
      .round_i (round + round_t'(k)),
      .state_i (chain[k]),
      .state_o (chain[k+1])
    );
  end

  keccak_round_count #(
    .RoundsPerClock (RoundsPerClock)
  ) u_round_count (
    .clk_i  (clk_i),
    .rst_b  (rst_b),
    .clr_i  (rst_rnd | zeroize_i),
    .incr_i (inc_rnd),
    .cnt_o  (round),
    .err_o  (count_error)
  );

  // Completion pulse, lines up with the final storage update
  always_ff @(posedge clk_i or negedge rst_b) begin
    if (!rst_b) begin
      complete_q <= 1'b0;
    end else begin
      complete_q <= complete_d & ~zeroize_i;
    end
  end

  assign status_o = '{
    ready:       (st_q == StIdle),
    complete:    complete_q,
    fsm_error:   fsm_error,
    count_error: count_error,
    clear_error: clear_error
  };

  ////////////////////////////////
  // Assertions
  ////////////////////////////////

  // Rounds per clock must split the permutation evenly
  if ((RoundsPerClock < 1) || (RoundsPerClock > 3) ||
      ((NumRounds % RoundsPerClock) != 0)) begin : gen_rpc_chk
    $error("RoundsPerClock must be 1, 2 or 3");
  end

  // Caller waits for ready before run
  RunInIdle_A: assert property (@(posedge clk_i) disable iff (!rst_b)
    run_i |-> (st_q == StIdle));

  NoErrorState_A: assert property (@(posedge clk_i) disable iff (!rst_b)
    st_q != StError);

endmodule

`default_nettype wire

/* source/keccak_perm.sv */
// Keccak-f[200] permutation engine top level
`default_nettype none

module keccak_perm #(
  parameter int RoundsPerClock = 1
) (
  input  logic                           clk_i,
  input  logic                           rst_b,
  input  logic                           zeroize_i,
  input  logic                           run_i,
  input  logic                           squeezing_i,
  input  logic                           clear_i,
  input  keccak_geom_pkg::state_t        data_i,
  output keccak_geom_pkg::state_t        state_o,
  output keccak_ctrl_pkg::round_status_t status_o
);

  // Round engine with storage and controller
  keccak_round #(
    .RoundsPerClock (RoundsPerClock)
  ) u_round (
    .clk_i       (clk_i),
    .rst_b       (rst_b),
    .zeroize_i   (zeroize_i),
    .run_i       (run_i),
    .squeezing_i (squeezing_i),
    .clear_i     (clear_i),
    .data_i      (data_i),
    .state_o     (state_o),
    .status_o    (status_o)
  );

endmodule

`default_nettype wire

/* verification/keccak_model_pkg.sv */
// Reference model of Keccak-f[200] rounds, permutation, absorb and squeeze
`default_nettype none

package keccak_model_pkg;
  import keccak_geom_pkg::*;

  // Lane rotation towards the MSB, any amount
  function automatic lane_t lane_rotl(lane_t a, int n);
    int m;
    m = n % LaneW;
    if (m == 0) begin
      return a;
    end
    return lane_t'((a << m) | (a >> (LaneW - m)));
  endfunction

  // Output bit t of the LFSR x^8+x^6+x^5+x^4+1
  function automatic logic lfsr_bit(int t);
    logic [8:0] r;
    int n;
    n = t % 255;
    r = 9'h001;
    for (int i = 0; i < n; i++) begin
      r = {r[7:0], 1'b0};
      // Feedback taps, also clears bit 8
      if (r[8]) begin
        r = r ^ 9'h171;
      end
    end
    return r[0];
  endfunction

  // Iota constant, bit 2^j-1 taken from LFSR output j + 7*round
  function automatic lane_t round_const(int rnd);
    lane_t rc;
    rc = '0;
    for (int j = 0; j < 4; j++) begin
      rc[(1 << j) - 1] = lfsr_bit(j + 7 * rnd);
    end
    return rc;
  endfunction

  // Rho offset from the walk (x,y) -> (y, 2x+3y) starting at (1,0)
  function automatic int rho_offset(int lx, int ly);
    int x;
    int y;
    int tmp;
    int off;
    x = 1;
    y = 0;
    off = 0;
    for (int t = 0; t < 24; t++) begin
      if ((x == lx) && (y == ly)) begin
        off = ((t + 1) * (t + 2) / 2) % LaneW;
      end
      tmp = y;
      y = (2 * x + 3 * y) % 5;
      x = tmp;
    end
    return off;
  endfunction

  // One full round on a packed state
  function automatic state_t apply_round(state_t s, int rnd);
    lane_t a [5][5];
    lane_t b [5][5];
    lane_t c [5];
    lane_t d [5];
    state_t r;
    for (int y = 0; y < 5; y++) begin
      for (int x = 0; x < 5; x++) begin
        a[x][y] = s[LaneW*(x+5*y) +: LaneW];
      end
    end
    // Theta
    for (int x = 0; x < 5; x++) begin
      c[x] = a[x][0] ^ a[x][1] ^ a[x][2] ^ a[x][3] ^ a[x][4];
    end
    for (int x = 0; x < 5; x++) begin
      d[x] = c[(x+4)%5] ^ lane_rotl(c[(x+1)%5], 1);
    end
    // Rho and pi
    for (int y = 0; y < 5; y++) begin
      for (int x = 0; x < 5; x++) begin
        b[y][(2*x+3*y)%5] = lane_rotl(a[x][y] ^ d[x], rho_offset(x, y));
      end
    end
    // Chi
    for (int y = 0; y < 5; y++) begin
      for (int x = 0; x < 5; x++) begin
        a[x][y] = b[x][y] ^ (~b[(x+1)%5][y] & b[(x+2)%5][y]);
      end
    end
    // Iota
    a[0][0] = a[0][0] ^ round_const(rnd);
    for (int y = 0; y < 5; y++) begin
      for (int x = 0; x < 5; x++) begin
        r[LaneW*(x+5*y) +: LaneW] = a[x][y];
      end
    end
    return r;
  endfunction

  function automatic state_t permute(state_t s);
    state_t r;
    r = s;
    for (int i = 0; i < NumRounds; i++) begin
      r = apply_round(r, i);
    end
    return r;
  endfunction

  // Message XOR then permutation
  function automatic state_t absorb(state_t s, state_t data);
    return permute(s ^ data);
  endfunction

  // Permutation only, no message
  function automatic state_t squeeze(state_t s);
    return permute(s);
  endfunction

endpackage

`default_nettype wire

/* verification/tb_keccak_perm.sv */
// Keccak-f[200] engine testbench with clock, reset, random runs, compare tasks and watchdog
`default_nettype none

module tb_keccak_perm #(
  parameter int RoundsPerClock = 1
);
  import keccak_geom_pkg::*;
  import keccak_ctrl_pkg::*;
  import keccak_model_pkg::*;

  localparam int ClkPeriod   = 40;
  localparam int ResetCycles = 8;
  // Edges from the sampling edge to completion
  localparam int RunEdges    = NumRounds / RoundsPerClock;
  localparam int NumAbsorb   = 8;
  localparam int NumZeroize  = 3;
  // Zeroize runs count double since they watch idle afterwards
  localparam int NumRuns     = 2 * NumAbsorb + 2 + 3 * NumZeroize;
  localparam int WatchdogTime =
    (NumRuns * (NumRounds + 4) + ResetCycles + 10) * ClkPeriod;

  logic          clk_i;
  logic          rst_b;
  logic          zeroize_i;
  logic          run_i;
  logic          squeezing_i;
  logic          clear_i;
  state_t        data_i;
  state_t        state_o;
  round_status_t status_o;

  // Model's view of the stored state
  state_t        exp_state;

  keccak_perm #(
    .RoundsPerClock (RoundsPerClock)
  ) u_dut (
    .clk_i       (clk_i),
    .rst_b       (rst_b),
    .zeroize_i   (zeroize_i),
    .run_i       (run_i),
    .squeezing_i (squeezing_i),
    .clear_i     (clear_i),
    .data_i      (data_i),
    .state_o     (state_o),
    .status_o    (status_o)
  );

  //////////////////////////////
  // Clock and watchdog
  //////////////////////////////

  initial clk_i = 1'b0;
  always #(ClkPeriod / 2) clk_i = ~clk_i;

  initial begin
    #(WatchdogTime);
    $display("Watchdog expired after %0d time units, the DUT hung", WatchdogTime);
    $display("Result: FAILED");
    $fatal(1, "watchdog timeout");
  end

  //////////////////////////////
  // Helpers and compare tasks
  //////////////////////////////

  function automatic state_t rand_state();
    logic [223:0] w;
    for (int i = 0; i < 7; i++) begin
      w[32*i +: 32] = $urandom;
    end
    return w[StateW-1:0];
  endfunction

  function automatic logic rand_bit();
    return ($urandom_range(1, 0) == 1);
  endfunction

  // Expected status with all error flags clear
  function automatic round_status_t expect_status(logic ready, logic complete);
    round_status_t s;
    s = '0;
    s.ready = ready;
    s.complete = complete;
    return s;
  endfunction

  task automatic check_state(string name, state_t exp, state_t act);
    if (act !== exp) begin
      $display("CHECK FAILED: %s expected %h actual %h", name, exp, act);
      $display("Result: FAILED");
      $fatal(1, "state mismatch in %s", name);
    end
  endtask

  task automatic check_status(string name, round_status_t exp, round_status_t act);
    if (act !== exp) begin
      $display("CHECK FAILED: %s expected %b actual %b", name, exp, act);
      $display("Result: FAILED");
      $fatal(1, "status mismatch in %s", name);
    end
  endtask

  //////////////////////////////
  // Test sequences
  //////////////////////////////

  // Entered and left at a falling edge with the engine idle
  task automatic run_perm(string name, logic squeeze_run, state_t data);
    check_status($sformatf("%s ready", name), expect_status(1'b1, 1'b0), status_o);
    run_i       = 1'b1;
    squeezing_i = squeeze_run;
    data_i      = data;
    if (squeeze_run) begin
      exp_state = squeeze(exp_state);
    end else begin
      exp_state = absorb(exp_state, data);
    end
    @(negedge clk_i);
    run_i       = 1'b0;
    squeezing_i = rand_bit();
    // Not sampled outside run_i
    data_i      = rand_state();
    check_status($sformatf("%s busy", name), expect_status(1'b0, 1'b0), status_o);
    for (int k = 1; k <= RunEdges; k++) begin
      @(negedge clk_i);
      if (k < RunEdges) begin
        check_status($sformatf("%s busy", name), expect_status(1'b0, 1'b0), status_o);
      end
    end
    check_status($sformatf("%s complete", name), expect_status(1'b1, 1'b1), status_o);
    check_state($sformatf("%s result", name), exp_state, state_o);
    @(negedge clk_i);
    // Pulse lasts one cycle
    check_status($sformatf("%s after", name), expect_status(1'b1, 1'b0), status_o);
    check_state($sformatf("%s held", name), exp_state, state_o);
  endtask

  // Clear wins over a competing run pulse
  task automatic clear_in_idle(string name);
    clear_i     = 1'b1;
    run_i       = rand_bit();
    squeezing_i = rand_bit();
    data_i      = rand_state();
    @(negedge clk_i);
    clear_i   = 1'b0;
    run_i     = 1'b0;
    exp_state = '0;
    check_state(name, exp_state, state_o);
    check_status(name, expect_status(1'b1, 1'b0), status_o);
  endtask

  // Zeroize stop_at edges into an absorb run
  task automatic zeroize_during_run(string name, int stop_at);
    check_status($sformatf("%s ready", name), expect_status(1'b1, 1'b0), status_o);
    run_i       = 1'b1;
    squeezing_i = 1'b0;
    data_i      = rand_state();
    @(negedge clk_i);
    run_i = 1'b0;
    check_status($sformatf("%s busy", name), expect_status(1'b0, 1'b0), status_o);
    repeat (stop_at) begin
      @(negedge clk_i);
      check_status($sformatf("%s busy", name), expect_status(1'b0, 1'b0), status_o);
    end
    zeroize_i = 1'b1;
    @(negedge clk_i);
    zeroize_i = 1'b0;
    exp_state = '0;
    check_state($sformatf("%s cleared", name), exp_state, state_o);
    check_status($sformatf("%s idle", name), expect_status(1'b1, 1'b0), status_o);
    // No late completion pulse
    repeat (RunEdges + 1) begin
      @(negedge clk_i);
      check_status($sformatf("%s quiet", name), expect_status(1'b1, 1'b0), status_o);
    end
  endtask

  //////////////////////////////
  // Main sequence
  //////////////////////////////

  initial begin
    void'($urandom(32'h8e56));
    rst_b       = 1'b0;
    zeroize_i   = 1'b0;
    run_i       = 1'b0;
    squeezing_i = 1'b0;
    clear_i     = 1'b0;
    data_i      = '0;
    exp_state   = '0;
    repeat (ResetCycles) @(negedge clk_i);
    rst_b = 1'b1;
    @(negedge clk_i);
    check_state("after reset", '0, state_o);
    check_status("after reset", expect_status(1'b1, 1'b0), status_o);

    // Absorb each block, then squeeze it
    for (int i = 0; i < NumAbsorb; i++) begin
      run_perm($sformatf("absorb %0d", i), 1'b0, rand_state());
      run_perm($sformatf("squeeze %0d", i), 1'b1, rand_state());
    end

    clear_in_idle("clear in idle");
    run_perm("absorb after clear", 1'b0, rand_state());

    for (int i = 0; i < NumZeroize; i++) begin
      zeroize_during_run($sformatf("zeroize %0d", i), $urandom_range(RunEdges - 1, 0));
      run_perm($sformatf("absorb after zeroize %0d", i), 1'b0, rand_state());
    end

    $display("Result: PASSED");
    $finish;
  end

endmodule

`default_nettype wire

/* project.f */
source/keccak_geom_pkg.sv
source/keccak_ctrl_pkg.sv
source/keccak_rc_table.sv
source/keccak_step.sv
source/keccak_round_count.sv
source/keccak_round.sv
source/keccak_perm.sv
verification/keccak_model_pkg.sv
verification/tb_keccak_perm.sv

/* Makefile */
# Verilator build and run for the Keccak-f[200] engine testbench

VERILATOR ?= verilator
TOP       ?= tb_keccak_perm
FILELIST  ?= project.f
RPC       ?= 1
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the testbench with Verilator"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST RPC BUILD_DIR VFLAGS"
	@echo "Example: make test RPC=3"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		-GRoundsPerClock=$(RPC) --Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
